// File: array/processing_element.sv
module processing_element
  import matmul_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  data_t in_a,
  input  data_t in_b,
  output data_t out_a,
  output data_t out_b,
  output data_t out_c
);

  acc_t acc;
  acc_t prod;

  // Operands move one hop right and down per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // Full product, widened before the add
  assign prod = in_a * in_b;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else begin
      acc <= acc + prod;
    end
  end

  // Saturate to all ones once anything spills past DATA_W
  assign out_c = (|acc[ACC_W-1:DATA_W]) ? '1 : acc[DATA_W-1:0];

endmodule

// File: array/systolic_array.sv
module systolic_array
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      clear,
  input  lane_vec_t a_skewed,
  input  lane_vec_t b_skewed,
  input  logic      rd_en,
  input  addr_t     rd_row,
  output lane_vec_t row_out
);

  // A travels along rows, one extra column for the right edge
  wire data_t a_h [MAT_SIZE][MAT_SIZE+1];

  // B travels down columns, one extra row for the bottom edge
  wire data_t b_v [MAT_SIZE+1][MAT_SIZE];

  // Saturated results straight from the cells
  wire lane_vec_t c_rows [MAT_SIZE];

  // Results as they stood when the run ended
  lane_vec_t res_rows [MAT_SIZE];

  //////////////////////////////////////////////////////////////
  // Edge inputs from the feeders
  //////////////////////////////////////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_edge
    assign a_h[i][0] = a_skewed[i];
    assign b_v[0][i] = b_skewed[i];
  end

  //////////////////////////////////////////////////////////////
  // Processing element grid
  //////////////////////////////////////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
      processing_element pe_i (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_h[i][j]),
        .in_b  (b_v[i][j]),
        .out_a (a_h[i][j+1]),
        .out_b (b_v[i+1][j]),
        .out_c (c_rows[i][j])
      );
    end
  end

  //////////////////////////////////////////////////////////////
  // Result hold and row readout
  //////////////////////////////////////////////////////////////

  // Tracks the cells during a run and freezes once clear rises,
  // so the host still sees C after start falls
  always_ff @(posedge clk) begin
    if (!clear) begin
      res_rows <= c_rows;
    end
  end

  // Zeros unless a row is requested
  always_ff @(posedge clk) begin
    if (reset) begin
      row_out <= '0;
    end else if (rd_en) begin
      row_out <= res_rows[rd_row];
    end else begin
      row_out <= '0;
    end
  end

  // Readout only between runs
  a_no_read_in_run : assert property (
    @(posedge clk) disable iff (reset) !clear |-> !rd_en
  );

endmodule

// File: common/matmul_pkg.sv
package matmul_pkg;

  //////////////////////////////////////////////////////////////
  // Array geometry and widths
  //////////////////////////////////////////////////////////////

  // Edge of the square matrices, also the lane count
  localparam int MAT_SIZE = 4;

  // Operand and result width
  localparam int DATA_W = 16;

  // Room for four full-width products without wrap
  localparam int ACC_W = 2 * DATA_W + 2;

  // Operand memory and result row address
  localparam int ADDR_W = 2;

  // Step counter width
  localparam int STEP_W = 5;

  //////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ACC_W-1:0]  acc_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STEP_W-1:0] step_t;

  // One word per matrix row or column, lane 0 in the low bits
  typedef data_t [MAT_SIZE-1:0] lane_vec_t;

  // Fetch 4, memory read 1, skew 3, grid hops 6, accumulate 1, margin 1
  localparam step_t DONE_COUNT = step_t'(16);

endpackage

// File: feeder/operand_feeder.sv
module operand_feeder
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      fetch,
  input  logic      we,
  input  addr_t     wr_addr,
  input  lane_vec_t wr_data,
  output lane_vec_t skewed
);

  addr_t     rd_addr;
  addr_t     ram_addr;
  lane_vec_t ram_q;
  logic      fetch_d;
  lane_vec_t gated;

  //////////////////////////////////////////////////////////////
  // Operand memory and its address
  //////////////////////////////////////////////////////////////

  // Host address wins on a write
  assign ram_addr = we ? wr_addr : rd_addr;

  // Walks words 0..3 during the fetch window, parked at 0 otherwise
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr <= '0;
    end else if (fetch) begin
      rd_addr <= rd_addr + 1'b1;
    end else begin
      rd_addr <= '0;
    end
  end

  operand_ram ram_i (
    .clk  (clk),
    .we   (we),
    .addr (ram_addr),
    .d    (wr_data),
    .q    (ram_q)
  );

  // Window delayed by the read latency
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_d <= 1'b0;
    end else begin
      fetch_d <= fetch;
    end
  end

  // Zeros outside the window keep the grid idle
  assign gated = fetch_d ? ram_q : '0;

  //////////////////////////////////////////////////////////////
  // Diagonal skew, lane i delayed by i cycles
  //////////////////////////////////////////////////////////////

  assign skewed[0] = gated[0];

  for (genvar i = 1; i < MAT_SIZE; i++) begin : g_skew
    data_t dly [i];

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int k = 0; k < i; k++) begin
          dly[k] <= '0;
        end
      end else begin
        dly[0] <= gated[i];
        for (int k = 1; k < i; k++) begin
          dly[k] <= dly[k-1];
        end
      end
    end

    assign skewed[i] = dly[i-1];
  end

  // Host loads only between runs
  a_no_write_in_fetch : assert property (
    @(posedge clk) disable iff (reset) !(we && fetch)
  );

endmodule

// File: feeder/operand_ram.sv
module operand_ram
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      we,
  input  addr_t     addr,
  input  lane_vec_t d,
  output lane_vec_t q
);

  // One lane vector per matrix column (A) or row (B)
  lane_vec_t mem [MAT_SIZE];

  // Write-first, so a write shows its own data on q
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= d;
      q <= d;
    end else begin
      q <= mem[addr];
    end
  end

endmodule

// File: flist.f
common/matmul_pkg.sv
feeder/operand_ram.sv
feeder/operand_feeder.sv
logic/matmul_control.sv
array/processing_element.sv
array/systolic_array.sv
logic/matmul_top.sv
tests/matmul_checker.sv
tests/matmul_tb.sv

// File: logic/matmul_control.sv
module matmul_control
  import matmul_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic start_mat_mul,
  output logic fetch,
  output logic clear,
  output logic done_mat_mul
);

  step_t step_cnt;

  //////////////////////////////////////////////////////////////
  // Step counter
  //////////////////////////////////////////////////////////////

  // Runs while start is held, freezes at the done count
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      step_cnt <= '0;
      done_mat_mul <= 1'b0;
    end else if (step_cnt == DONE_COUNT) begin
      done_mat_mul <= 1'b1;
    end else begin
      step_cnt <= step_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////
  // Decodes
  //////////////////////////////////////////////////////////////

  // One memory word per step for the first MAT_SIZE steps
  assign fetch = start_mat_mul && (step_cnt < step_t'(MAT_SIZE));

  // Accumulators held at zero between runs
  assign clear = !start_mat_mul;

  // Done only after start was held for a whole run
  a_done_after_full_run : assert property (
    @(posedge clk) disable iff (reset)
    done_mat_mul |-> $past(start_mat_mul) && $past(start_mat_mul, int'(DONE_COUNT) + 1)
  );

endmodule

// File: logic/matmul_top.sv
module matmul_top
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  lane_vec_t data_pi,
  input  addr_t     addr_pi,
  input  logic      we_a,
  input  logic      we_b,
  input  logic      start_mat_mul,
  input  logic      enable_reading_from_mem,
  output lane_vec_t data_from_out_mat,
  output logic      done_mat_mul
);

  logic      fetch;
  logic      clear;
  lane_vec_t a_skewed;
  lane_vec_t b_skewed;

  matmul_control control_i (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .fetch         (fetch),
    .clear         (clear),
    .done_mat_mul  (done_mat_mul)
  );

  //////////////////////////////////////////////////////////////
  // Operand feeders
  //////////////////////////////////////////////////////////////

  // A memory holds columns of A
  operand_feeder a_feeder_i (
    .clk     (clk),
    .reset   (reset),
    .fetch   (fetch),
    .we      (we_a),
    .wr_addr (addr_pi),
    .wr_data (data_pi),
    .skewed  (a_skewed)
  );

  // B memory holds rows of B
  operand_feeder b_feeder_i (
    .clk     (clk),
    .reset   (reset),
    .fetch   (fetch),
    .we      (we_b),
    .wr_addr (addr_pi),
    .wr_data (data_pi),
    .skewed  (b_skewed)
  );

  systolic_array array_i (
    .clk      (clk),
    .reset    (reset),
    .clear    (clear),
    .a_skewed (a_skewed),
    .b_skewed (b_skewed),
    .rd_en    (enable_reading_from_mem),
    .rd_row   (addr_pi),
    .row_out  (data_from_out_mat)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the matmul testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=matmul_sim

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module matmul_tb -f flist.f -o "$BIN"; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// File: tests/matmul_checker.sv
module matmul_checker
  import matmul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  lane_vec_t data_pi,
  input  addr_t     addr_pi,
  input  logic      we_a,
  input  logic      we_b,
  input  logic      start_mat_mul,
  input  logic      enable_reading_from_mem,
  input  lane_vec_t data_from_out_mat,
  input  logic      done_mat_mul,
  output int        error_count,
  output int        check_count
);

  // Edges from the first start sample to done
  localparam int DONE_EDGES = int'(DONE_COUNT) + 1;
  localparam longint unsigned SAT_MAX = 64'd65535;

  data_t     a_mat [MAT_SIZE][MAT_SIZE];
  data_t     b_mat [MAT_SIZE][MAT_SIZE];
  logic      armed;
  lane_vec_t exp_row;
  addr_t     exp_addr;
  logic      exp_done;
  int        run_edges;

  // Reference row r of C, clipped at the largest 16-bit value
  function automatic lane_vec_t product_row(input addr_t r);
    lane_vec_t       row;
    longint unsigned sum;
    longint unsigned a_val;
    longint unsigned b_val;
    for (int j = 0; j < MAT_SIZE; j++) begin
      sum = 0;
      for (int k = 0; k < MAT_SIZE; k++) begin
        a_val = a_mat[r][k];
        b_val = b_mat[k][j];
        sum = sum + a_val * b_val;
      end
      row[j] = (sum > SAT_MAX) ? 16'hffff : data_t'(sum);
    end
    return row;
  endfunction

  initial begin
    armed = 1'b0;
    error_count = 0;
    check_count = 0;
    run_edges = 0;
    exp_done = 1'b0;
    exp_row = '0;
    exp_addr = '0;
  end

  //////////////////////////////////////////////////////////////
  // Compare against last edge's expectations, then update
  //////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (armed) begin
      check_count = check_count + 2;
      if (data_from_out_mat !== exp_row) begin
        error_count = error_count + 1;
        $display("[ERROR] %0t: readout for row %0d gave %h, expected %h",
                 $time, exp_addr, data_from_out_mat, exp_row);
      end
      if (done_mat_mul !== exp_done) begin
        error_count = error_count + 1;
        $display("[ERROR] %0t: done_mat_mul is %b, expected %b after %0d start edges",
                 $time, done_mat_mul, exp_done, run_edges);
      end
    end

    // Zeros unless a row was requested
    if (reset || !enable_reading_from_mem) begin
      exp_row = '0;
    end else begin
      exp_row = product_row(addr_pi);
    end
    exp_addr = addr_pi;

    if (reset || !start_mat_mul) begin
      run_edges = 0;
    end else if (run_edges < DONE_EDGES) begin
      run_edges = run_edges + 1;
    end
    exp_done = (run_edges >= DONE_EDGES);

    // Snoop host loads: A by columns, B by rows
    if (!reset && we_a) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        a_mat[i][addr_pi] = data_pi[i];
      end
    end
    if (!reset && we_b) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        b_mat[addr_pi][j] = data_pi[j];
      end
    end
    armed = 1'b1;
  end

endmodule

// File: tests/matmul_tb.sv
module matmul_tb
  import matmul_pkg::*;
();

  localparam int NUM_TESTS = 20;
  localparam int SMALL_TESTS = 8;
  localparam int CYCLES_PER_TEST = 60;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * CYCLES_PER_TEST + 200;
  localparam logic [31:0] SEED = 32'h5a59_d245;

  logic      clk;
  logic      reset;
  lane_vec_t data_pi;
  addr_t     addr_pi;
  logic      we_a;
  logic      we_b;
  logic      start_mat_mul;
  logic      enable_reading_from_mem;
  lane_vec_t data_from_out_mat;
  logic      done_mat_mul;
  int        error_count;
  int        check_count;
  int        cycle_count;

  // Stimulus copies, A[i][k] and B[k][j]
  data_t a_mat [MAT_SIZE][MAT_SIZE];
  data_t b_mat [MAT_SIZE][MAT_SIZE];

  matmul_top dut_i (
    .clk                     (clk),
    .reset                   (reset),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .start_mat_mul           (start_mat_mul),
    .enable_reading_from_mem (enable_reading_from_mem),
    .data_from_out_mat       (data_from_out_mat),
    .done_mat_mul            (done_mat_mul)
  );

  matmul_checker checker_i (
    .clk                     (clk),
    .reset                   (reset),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .start_mat_mul           (start_mat_mul),
    .enable_reading_from_mem (enable_reading_from_mem),
    .data_from_out_mat       (data_from_out_mat),
    .done_mat_mul            (done_mat_mul),
    .error_count             (error_count),
    .check_count             (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Hard stop in case done never arrives
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////

  // Mixed mode: full range, zero or small, so some results clip
  function automatic data_t random_element(input bit full_range);
    int unsigned pick;
    pick = $urandom % 4;
    if (!full_range) begin
      // Below 128 four products stay under 65536
      return data_t'($urandom % 128);
    end
    if (pick == 0) begin
      return data_t'($urandom);
    end else if (pick == 1) begin
      return '0;
    end
    return data_t'($urandom % 16);
  endfunction

  task automatic fill_matrices(input bit full_range);
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        a_mat[i][j] = random_element(full_range);
        b_mat[i][j] = random_element(full_range);
      end
    end
  endtask

  task automatic load_operands();
    // A columns first
    for (int k = 0; k < MAT_SIZE; k++) begin
      @(negedge clk);
      for (int i = 0; i < MAT_SIZE; i++) begin
        data_pi[i] = a_mat[i][k];
      end
      addr_pi = addr_t'(k);
      we_a = 1'b1;
    end
    @(negedge clk);
    we_a = 1'b0;
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        data_pi[j] = b_mat[k][j];
      end
      addr_pi = addr_t'(k);
      we_b = 1'b1;
      @(negedge clk);
    end
    we_b = 1'b0;
    data_pi = '0;
    addr_pi = '0;
  endtask

  // Hold start a few cycles past done, then let it fall
  task automatic run_product();
    @(negedge clk);
    start_mat_mul = 1'b1;
    while (done_mat_mul !== 1'b1) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
    start_mat_mul = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic read_rows();
    for (int r = 0; r < MAT_SIZE; r++) begin
      @(negedge clk);
      addr_pi = addr_t'(r);
      enable_reading_from_mem = 1'b1;
    end
    // Address present but read not enabled
    @(negedge clk);
    enable_reading_from_mem = 1'b0;
    addr_pi = addr_t'($urandom % MAT_SIZE);
    @(negedge clk);
    addr_pi = '0;
  endtask

  //////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    data_pi = '0;
    addr_pi = '0;
    we_a = 1'b0;
    we_b = 1'b0;
    start_mat_mul = 1'b0;
    enable_reading_from_mem = 1'b0;
    void'($urandom(SEED));
    repeat (4) @(negedge clk);
    reset = 1'b0;
    repeat (2) @(negedge clk);

    // Small operands first, then clipping cases
    for (int t = 0; t < NUM_TESTS; t++) begin
      fill_matrices(t >= SMALL_TESTS);
      load_operands();
      run_product();
      read_rows();
    end

    repeat (2) @(negedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
